// File: hw/memIfPkg.sv
`default_nettype none

package memIfPkg;

   // ********************
   // bus and memory widths
   // ********************

   // the host side is a byte-wide Wishbone classic slave
   localparam int busAddrW = 8;
   localparam int busDataW = 8;

   // the CellRAM side is 23 address bits and a 16-bit data bus
   localparam int memAddrW = 23;
   localparam int memDataW = 16;

   // strobes stay low for five cycles, 100 ns covers the 85 ns access time
   localparam int accessCycles = 5;

   // ********************
   // register map
   // ********************

   // address bytes, the top bit of regAddr2 is dropped
   localparam logic [busAddrW-1:0] regAddr0    = 8'h11;
   localparam logic [busAddrW-1:0] regAddr1    = 8'h12;
   localparam logic [busAddrW-1:0] regAddr2    = 8'h13;
   // write data bytes
   localparam logic [busAddrW-1:0] regWdata0   = 8'h14;
   localparam logic [busAddrW-1:0] regWdata1   = 8'h15;
   // captured read data, read only
   localparam logic [busAddrW-1:0] regRdata0   = 8'h16;
   localparam logic [busAddrW-1:0] regRdata1   = 8'h17;
   // command strobes, the data byte is not used
   localparam logic [busAddrW-1:0] regCmdRead  = 8'h18;
   localparam logic [busAddrW-1:0] regCmdWrite = 8'h19;
   // bit 0 is ready
   localparam logic [busAddrW-1:0] regStatus   = 8'h1A;

   // one-hot select of the five writable holding registers
   typedef struct packed {
      logic wdata1;
      logic wdata0;
      logic addr2;
      logic addr1;
      logic addr0;
   } regSelT;

   // register write from the decoder to the holding registers
   typedef struct packed {
      regSelT              sel;
      logic [busDataW-1:0] data;
   } regWriteT;

   // start is a single-cycle pulse, isWrite is only looked at with start
   typedef struct packed {
      logic start;
      logic isWrite;
   } memCmdT;

   // SRAM control, drive high means the bridge owns the data bus
   typedef struct packed {
      logic ceN;
      logic oeN;
      logic weN;
      logic drive;
   } sramPinsT;

endpackage

`default_nettype wire

// File: hw/wbRegDecoder.sv
`default_nettype none

module wbRegDecoder import memIfPkg::*; (
   input  wire logic                clk,
   input  wire logic                rstsb,
   input  wire logic                cyc,
   input  wire logic                stb,
   input  wire logic                we,
   input  wire logic [busAddrW-1:0] adr,
   input  wire logic [busDataW-1:0] datW,
   output      logic [busDataW-1:0] datR,
   output      logic                ack,
   output      regWriteT            regWrite,
   output      memCmdT              memCmd,
   input  wire logic                ready,
   input  wire logic [memDataW-1:0] rdData
);

   logic                req;
   logic                cmdRead;
   logic                cmdWrite;
   logic                cmdHit;
   logic                accept;
   logic [busDataW-1:0] readByte;

   // a new request is one that has not been acked yet
   // the master holds stb through the ack cycle, so it is masked here
   assign req = cyc && stb && !ack;

   // ********************
   // address decode
   // ********************

   // one case statement covers writes, commands and the read-back mux
   always_comb begin
      regWrite      = '0;
      regWrite.data = datW;
      cmdRead       = 1'b0;
      cmdWrite      = 1'b0;
      readByte      = '0;
      if (req && we) begin
         case (adr)
            regAddr0:    regWrite.sel.addr0  = 1'b1;
            regAddr1:    regWrite.sel.addr1  = 1'b1;
            regAddr2:    regWrite.sel.addr2  = 1'b1;
            regWdata0:   regWrite.sel.wdata0 = 1'b1;
            regWdata1:   regWrite.sel.wdata1 = 1'b1;
            regCmdRead:  cmdRead             = 1'b1;
            regCmdWrite: cmdWrite            = 1'b1;
            // unmapped writes are acked and dropped
            default:     ;
         endcase
      end else if (req) begin
         case (adr)
            regRdata0: readByte = rdData[busDataW-1:0];
            regRdata1: readByte = rdData[memDataW-1:busDataW];
            regStatus: readByte = {{(busDataW-1){1'b0}}, ready};
            default:   readByte = '0;
         endcase
      end
   end

   // a command waits for ready, everything else goes through at once
   assign cmdHit = cmdRead || cmdWrite;
   assign accept = req && (!cmdHit || ready);

   // ********************
   // registered bus side
   // ********************

   // ack, start and the read byte all show up one cycle after the request
   always_ff @(posedge clk or negedge rstsb) begin
      if (!rstsb) begin
         ack    <= 1'b0;
         memCmd <= '0;
         datR   <= '0;
      end else begin
         ack          <= accept;
         memCmd.start <= cmdHit && ready;
         if (cmdHit && ready) begin
            memCmd.isWrite <= cmdWrite;
         end
         if (accept) begin
            datR <= readByte;
         end
      end
   end

   // ack is a reply, so the master must still be holding the cycle open
   assert property (@(posedge clk) disable iff (!rstsb)
      $rose(ack) |-> $past(cyc && stb) && cyc && stb);

   // start only goes out to an idle sequencer, which then drops ready
   assert property (@(posedge clk) disable iff (!rstsb)
      memCmd.start |-> ready ##1 !ready);

endmodule

`default_nettype wire

// File: hw/memRegBank.sv
`default_nettype none

module memRegBank import memIfPkg::*; (
   input  wire logic                clk,
   input  wire logic                rstsb,
   input  wire regWriteT            regWrite,
   input  wire logic                readLd,
   output      logic [memAddrW-1:0] memAddr,
   output      logic [memDataW-1:0] memDataOut,
   input  wire logic [memDataW-1:0] memDataIn,
   output      logic [memDataW-1:0] rdData
);

   // ********************
   // staging registers
   // ********************

   // the address arrives a byte at a time, only seven bits of the top byte exist
   logic [busDataW-1:0]            addrLo;
   logic [busDataW-1:0]            addrMid;
   logic [memAddrW-2*busDataW-1:0] addrHi;
   logic [busDataW-1:0]            wdataLo;
   logic [busDataW-1:0]            wdataHi;
   // both halves of the last read word
   logic [memDataW-1:0]            rdCapture;

   // each select bit loads one byte from the bus
   always_ff @(posedge clk or negedge rstsb) begin
      if (!rstsb) begin
         addrLo  <= '0;
         addrMid <= '0;
         addrHi  <= '0;
         wdataLo <= '0;
         wdataHi <= '0;
      end else begin
         if (regWrite.sel.addr0) begin
            addrLo <= regWrite.data;
         end
         if (regWrite.sel.addr1) begin
            addrMid <= regWrite.data;
         end
         // bit 7 of the third address byte is thrown away here
         if (regWrite.sel.addr2) begin
            addrHi <= regWrite.data[memAddrW-2*busDataW-1:0];
         end
         if (regWrite.sel.wdata0) begin
            wdataLo <= regWrite.data;
         end
         if (regWrite.sel.wdata1) begin
            wdataHi <= regWrite.data;
         end
      end
   end

   // ********************
   // read capture
   // ********************

   // readLd is high in the last cycle of a read window, the data is stable by then
   always_ff @(posedge clk or negedge rstsb) begin
      if (!rstsb) begin
         rdCapture <= '0;
      end else if (readLd) begin
         rdCapture <= memDataIn;
      end
   end

   // the staging bytes go straight to the pins, so a late write is seen at once
   assign memAddr    = {addrHi, addrMid, addrLo};
   assign memDataOut = {wdataHi, wdataLo};
   assign rdData     = rdCapture;

   // the decoder must never select two holding registers at once
   assert property (@(posedge clk) disable iff (!rstsb)
      $onehot0(regWrite.sel));

endmodule

`default_nettype wire

// File: hw/sramSequencer.sv
`default_nettype none

module sramSequencer import memIfPkg::*; (
   input  wire logic   clk,
   input  wire logic   rstsb,
   input  wire memCmdT memCmd,
   output      logic   ready,
   output      logic   readLd,
   output      sramPinsT pins
);

   // ********************
   // state and counter
   // ********************

   typedef enum logic [1:0] {
      stIdle,
      stRead,
      stWrite
   } seqStateT;

   seqStateT state;

   // counts the cycles of the access window from 0 up to accessCycles-1
   logic [$clog2(accessCycles)-1:0] winCnt;
   logic                            lastCycle;

   // high in the final cycle of the window so the strobes rise on the next edge
   assign lastCycle = (state != stIdle) &&
                      (winCnt == $bits(winCnt)'(accessCycles - 1));

   // the read word is stable by the last cycle and is captured on the closing edge
   assign readLd = lastCycle && (state == stRead);

   // ********************
   // access FSM
   // ********************

   // every strobe comes straight from a flop so the SRAM never sees a glitch
   always_ff @(posedge clk or negedge rstsb) begin
      if (!rstsb) begin
         state  <= stIdle;
         ready  <= 1'b1;
         winCnt <= '0;
         pins   <= '{ceN: 1'b1, oeN: 1'b1, weN: 1'b1, drive: 1'b0};
      end else begin
         case (state)
            stIdle: begin
               winCnt <= '0;
               if (memCmd.start) begin
                  // strobes and ready change on the cycle after start
                  ready <= 1'b0;
                  if (memCmd.isWrite) begin
                     state <= stWrite;
                     // a write drives the bus and pulls weN low while oeN stays high
                     pins  <= '{ceN: 1'b0, oeN: 1'b1, weN: 1'b0, drive: 1'b1};
                  end else begin
                     state <= stRead;
                     // a read releases the bus and lets the memory drive it
                     pins  <= '{ceN: 1'b0, oeN: 1'b0, weN: 1'b1, drive: 1'b0};
                  end
               end
            end
            stRead, stWrite: begin
               if (lastCycle) begin
                  // weN rising as the window closes is the SRAM write edge
                  state  <= stIdle;
                  ready  <= 1'b1;
                  winCnt <= '0;
                  pins   <= '{ceN: 1'b1, oeN: 1'b1, weN: 1'b1, drive: 1'b0};
               end else begin
                  winCnt <= winCnt + 1'b1;
               end
            end
            default: begin
               state  <= stIdle;
               ready  <= 1'b1;
               winCnt <= '0;
               pins   <= '{ceN: 1'b1, oeN: 1'b1, weN: 1'b1, drive: 1'b0};
            end
         endcase
      end
   end

   // ********************
   // checks
   // ********************

   // one access holds chip enable low for the full window and no longer
   assert property (@(posedge clk) disable iff (!rstsb)
      $fell(pins.ceN) |-> !pins.ceN [*accessCycles] ##1 pins.ceN);

   // output enable and write enable are never low at the same time
   assert property (@(posedge clk) disable iff (!rstsb)
      pins.oeN || pins.weN);

endmodule

`default_nettype wire

// File: hw/memIfTop.sv
`default_nettype none

module memIfTop import memIfPkg::*; (
   input  wire logic                clk,
   input  wire logic                rstsb,
   // Wishbone classic slave
   input  wire logic                cyc,
   input  wire logic                stb,
   input  wire logic                we,
   input  wire logic [busAddrW-1:0] adr,
   input  wire logic [busDataW-1:0] datW,
   output      logic [busDataW-1:0] datR,
   output      logic                ack,
   // CellRAM pins, the data bus is split into out, in and enable
   output      logic [memAddrW-1:0] memAddr,
   output      logic [memDataW-1:0] memDataOut,
   input  wire logic [memDataW-1:0] memDataIn,
   output      logic                memDataOe,
   output      logic                ceN,
   output      logic                oeN,
   output      logic                weN
);

   // ********************
   // internal wiring
   // ********************

   regWriteT            regWrite;
   memCmdT              memCmd;
   logic                ready;
   logic                readLd;
   logic [memDataW-1:0] rdData;
   sramPinsT            pins;

   // the bus side turns register accesses into writes and commands
   wbRegDecoder u0 (
      .clk      (clk),
      .rstsb    (rstsb),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .datW     (datW),
      .datR     (datR),
      .ack      (ack),
      .regWrite (regWrite),
      .memCmd   (memCmd),
      .ready    (ready),
      .rdData   (rdData)
   );

   // staging bytes feed the address and data pins
   memRegBank u1 (
      .clk        (clk),
      .rstsb      (rstsb),
      .regWrite   (regWrite),
      .readLd     (readLd),
      .memAddr    (memAddr),
      .memDataOut (memDataOut),
      .memDataIn  (memDataIn),
      .rdData     (rdData)
   );

   // runs one access window per command
   sramSequencer u2 (
      .clk    (clk),
      .rstsb  (rstsb),
      .memCmd (memCmd),
      .ready  (ready),
      .readLd (readLd),
      .pins   (pins)
   );

   // unpack the strobe bundle onto the pins
   assign ceN       = pins.ceN;
   assign oeN       = pins.oeN;
   assign weN       = pins.weN;
   assign memDataOe = pins.drive;

endmodule

`default_nettype wire

// File: sim/sramModel.sv
`default_nettype none

module sramModel import memIfPkg::*; (
   input  wire logic                ceN,
   input  wire logic                oeN,
   input  wire logic                weN,
   input  wire logic [memAddrW-1:0] memAddr,
   input  wire logic                memDataOe,
   input  wire logic [memDataW-1:0] memDataOut,
   output      logic [memDataW-1:0] memDataIn
);

   timeunit 1ns;
   timeprecision 100ps;

   // only written words are kept and everything else reads as the preset
   logic [memDataW-1:0] store [logic [memAddrW-1:0]];
   logic                pending = 1'b0;
   logic [memAddrW-1:0] pendAddr;
   logic [memDataW-1:0] pendData;

   // preset is the low address bits xor a5a5
   function automatic logic [memDataW-1:0] wordAt(input logic [memAddrW-1:0] a);
      if (store.exists(a)) begin
         return store[a];
      end
      return a[15:0] ^ 16'hA5A5;
   endfunction

   // the write data is only valid while the bridge drives the bus
   // the word is committed when the strobes go high again
   always @(ceN or weN or memDataOe or memAddr or memDataOut) begin
      if (!ceN && !weN && memDataOe) begin
         pendAddr = memAddr;
         pendData = memDataOut;
         pending  = 1'b1;
      end else if (pending && (weN || ceN)) begin
         store[pendAddr] = pendData;
         pending         = 1'b0;
      end
   end

   // bus resolution with the bridge taking priority and a pulled-up idle bus
   always @(ceN or oeN or memAddr or memDataOe or memDataOut) begin
      if (memDataOe) begin
         memDataIn = memDataOut;
      end else if (!ceN && !oeN) begin
         memDataIn = wordAt(memAddr);
      end else begin
         memDataIn = '1;
      end
   end

endmodule

`default_nettype wire

// File: sim/memIfChecker.sv
`default_nettype none

module memIfChecker import memIfPkg::*; (
   input  wire logic                clk,
   input  wire logic                rstsb,
   input  wire logic                cyc,
   input  wire logic                stb,
   input  wire logic                we,
   input  wire logic [busAddrW-1:0] adr,
   input  wire logic [busDataW-1:0] datR,
   input  wire logic                ack,
   input  wire logic                ceN,
   input  wire logic                oeN,
   input  wire logic                weN,
   input  wire logic                memDataOe,
   input  wire logic                expCheck,
   input  wire logic [busDataW-1:0] expData,
   output      int                  errCount
);

   timeunit 1ns;
   timeprecision 100ps;

   // kind of every acknowledged command in order with 1 meaning write
   bit   cmdKinds[$];
   logic curWrite;
   logic inWin;
   logic ceNPrev;
   int   winLen;
   logic cmdAck;

   assign cmdAck = cyc && stb && we && ack && (adr == regCmdRead || adr == regCmdWrite);

   task automatic flagMismatch(input string name, input int expV, input int actV);
      $display("[ERROR] %0d ns %s expected 0x%0h got 0x%0h", $time, name, expV, actV);
      errCount++;
   endtask

   task automatic noteFailure(input string msg);
      $display("%0d ns %s", $time, msg);
      errCount++;
   endtask

   // ********************
   // bus and pin monitor
   // ********************

   // everything is sampled on the rising edge where the DUT outputs are settled
   always @(posedge clk) begin
      if (!rstsb) begin
         errCount = 0;
         inWin    = 1'b0;
         winLen   = 0;
         ceNPrev  = 1'b1;
         curWrite = 1'b0;
         cmdKinds.delete();
      end else begin
         // a command may only be acked once the previous window has closed
         if (cmdAck) begin
            if (!ceN || !ceNPrev) begin
               noteFailure("a command was acknowledged while an SRAM access was in progress");
            end
            cmdKinds.push_back(adr == regCmdWrite);
         end
         // read data and ack arrive together
         if (cyc && stb && !we && ack && expCheck && datR !== expData) begin
            flagMismatch($sformatf("datR at 0x%0h", adr), int'(expData), int'(datR));
         end
         if (!ceN) begin
            // first cycle of a window takes the oldest acked command
            if (!inWin) begin
               inWin  = 1'b1;
               winLen = 0;
               if (cmdKinds.size() == 0) begin
                  noteFailure("an SRAM access started without an acknowledged command");
                  curWrite = 1'b0;
               end else begin
                  curWrite = cmdKinds.pop_front();
               end
            end
            winLen++;
            // a read enables the outputs and a write drives the bus and pulls weN
            if (oeN !== curWrite) begin
               flagMismatch("oeN", int'(curWrite), int'(oeN));
            end
            if (weN !== !curWrite) begin
               flagMismatch("weN", int'(!curWrite), int'(weN));
            end
            if (memDataOe !== curWrite) begin
               flagMismatch("memDataOe", int'(curWrite), int'(memDataOe));
            end
         end else begin
            if (inWin && winLen != accessCycles) begin
               flagMismatch("ceN low cycles", accessCycles, winLen);
            end
            inWin = 1'b0;
            if (oeN !== 1'b1 || weN !== 1'b1 || memDataOe !== 1'b0) begin
               noteFailure("oeN, weN or the bus drive was active while ceN was high");
            end
         end
         ceNPrev = ceN;
      end
   end

endmodule

`default_nettype wire

// File: sim/memIfTb.sv
`default_nettype none

module memIfTb import memIfPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {
      opWrite,
      opRead,
      opIdle
   } opT;

   // one table row is a bus access with its expected read byte
   typedef struct packed {
      opT                  op;
      logic [busAddrW-1:0] adr;
      logic [busDataW-1:0] data;
      logic [busDataW-1:0] expVal;
   } stepT;

   logic                clk;
   logic                rstsb;
   logic                cyc;
   logic                stb;
   logic                we;
   logic [busAddrW-1:0] adr;
   logic [busDataW-1:0] datW;
   logic [busDataW-1:0] datR;
   logic                ack;
   logic [memAddrW-1:0] memAddr;
   logic [memDataW-1:0] memDataOut;
   logic [memDataW-1:0] memDataIn;
   logic                memDataOe;
   logic                ceN;
   logic                oeN;
   logic                weN;
   logic                expCheck;
   logic [busDataW-1:0] expData;
   int                  errCount;

   stepT                steps[$];
   logic [memDataW-1:0] shadow [logic [memAddrW-1:0]];
   int                  timeouts;
   logic                aborted;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   memIfTop dut0 (
      .clk        (clk),
      .rstsb      (rstsb),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .datW       (datW),
      .datR       (datR),
      .ack        (ack),
      .memAddr    (memAddr),
      .memDataOut (memDataOut),
      .memDataIn  (memDataIn),
      .memDataOe  (memDataOe),
      .ceN        (ceN),
      .oeN        (oeN),
      .weN        (weN)
   );

   sramModel mem0 (
      .ceN        (ceN),
      .oeN        (oeN),
      .weN        (weN),
      .memAddr    (memAddr),
      .memDataOe  (memDataOe),
      .memDataOut (memDataOut),
      .memDataIn  (memDataIn)
   );

   memIfChecker chk0 (
      .clk       (clk),
      .rstsb     (rstsb),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .datR      (datR),
      .ack       (ack),
      .ceN       (ceN),
      .oeN       (oeN),
      .weN       (weN),
      .memDataOe (memDataOe),
      .expCheck  (expCheck),
      .expData   (expData),
      .errCount  (errCount)
   );

   // ********************
   // table building
   // ********************

   function automatic logic [busDataW-1:0] fillerByte();
      logic [31:0] r;
      r = $urandom;
      return r[7:0];
   endfunction

   // never written words hold the low address bits xor a5a5
   function automatic logic [memDataW-1:0] expectedWord(input logic [memAddrW-1:0] a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      return a[15:0] ^ 16'hA5A5;
   endfunction

   task automatic pushStep(input opT op, input logic [7:0] a, input logic [7:0] d,
                           input logic [7:0] e);
      stepT s;
      s.op     = op;
      s.adr    = a;
      s.data   = d;
      s.expVal = e;
      steps.push_back(s);
   endtask

   // bit 7 of the top byte is random since the bridge must drop it
   task automatic loadAddress(input logic [memAddrW-1:0] a);
      logic [7:0] junk;
      junk = fillerByte();
      pushStep(opWrite, regAddr0, a[7:0], 8'h00);
      pushStep(opWrite, regAddr1, a[15:8], 8'h00);
      pushStep(opWrite, regAddr2, {junk[7], a[22:16]}, 8'h00);
   endtask

   task automatic storeWord(input logic [memAddrW-1:0] a, input logic [memDataW-1:0] d);
      loadAddress(a);
      pushStep(opWrite, regWdata0, d[7:0], 8'h00);
      pushStep(opWrite, regWdata1, d[15:8], 8'h00);
      pushStep(opWrite, regCmdWrite, fillerByte(), 8'h00);
      pushStep(opIdle, 8'h00, 8'h00, 8'h00);
      shadow[a] = d;
   endtask

   task automatic fetchWord(input logic [memAddrW-1:0] a);
      logic [memDataW-1:0] w;
      w = expectedWord(a);
      loadAddress(a);
      pushStep(opWrite, regCmdRead, fillerByte(), 8'h00);
      pushStep(opIdle, 8'h00, 8'h00, 8'h00);
      pushStep(opRead, regRdata0, 8'h00, w[7:0]);
      pushStep(opRead, regRdata1, 8'h00, w[15:8]);
   endtask

   task automatic buildTable();
      logic [memAddrW-1:0] a;
      logic [memDataW-1:0] d;
      logic [31:0]         r;
      // idle after reset with clear read-back registers
      pushStep(opRead, regStatus, 8'h00, 8'h01);
      pushStep(opRead, regRdata0, 8'h00, 8'h00);
      pushStep(opRead, regRdata1, 8'h00, 8'h00);
      fetchWord(23'h000123);
      fetchWord(23'h7FFFFF);
      // write and read back while the neighbors keep their preset
      r = $urandom;
      storeWord(23'h000456, r[15:0]);
      fetchWord(23'h000456);
      fetchWord(23'h000455);
      fetchWord(23'h000457);
      // bit 22 set and its alias without bit 22 stays untouched
      r = $urandom;
      storeWord(23'h40A0C3, r[15:0]);
      fetchWord(23'h40A0C3);
      fetchWord(23'h00A0C3);
      fetchWord(23'h40A0C4);
      // status during a write and then a read that has to wait for ready
      a = 23'h2B3C4D;
      r = $urandom;
      d = r[15:0];
      loadAddress(a);
      pushStep(opWrite, regWdata0, d[7:0], 8'h00);
      pushStep(opWrite, regWdata1, d[15:8], 8'h00);
      pushStep(opWrite, regCmdWrite, fillerByte(), 8'h00);
      pushStep(opRead, regStatus, 8'h00, 8'h00);
      pushStep(opWrite, regCmdRead, fillerByte(), 8'h00);
      pushStep(opIdle, 8'h00, 8'h00, 8'h00);
      shadow[a] = d;
      pushStep(opRead, regRdata0, 8'h00, d[7:0]);
      pushStep(opRead, regRdata1, 8'h00, d[15:8]);
      // unmapped and write-only addresses read as zero
      pushStep(opRead, 8'h00, 8'h00, 8'h00);
      pushStep(opRead, 8'h1B, 8'h00, 8'h00);
      pushStep(opRead, 8'hFF, 8'h00, 8'h00);
      pushStep(opRead, regAddr0, 8'h00, 8'h00);
      // unmapped writes leave read-back and address and write data alone
      pushStep(opWrite, 8'h10, fillerByte(), 8'h00);
      pushStep(opWrite, 8'h1B, fillerByte(), 8'h00);
      pushStep(opWrite, 8'hFF, fillerByte(), 8'h00);
      pushStep(opRead, regRdata0, 8'h00, d[7:0]);
      pushStep(opRead, regRdata1, 8'h00, d[15:8]);
      pushStep(opWrite, regCmdRead, fillerByte(), 8'h00);
      pushStep(opIdle, 8'h00, 8'h00, 8'h00);
      pushStep(opRead, regRdata1, 8'h00, d[15:8]);
      loadAddress(23'h1357AC);
      pushStep(opWrite, regCmdWrite, fillerByte(), 8'h00);
      pushStep(opIdle, 8'h00, 8'h00, 8'h00);
      shadow[23'h1357AC] = d;
      fetchWord(23'h1357AC);
   endtask

   // ********************
   // Wishbone master
   // ********************

   // the ack sampled at an edge is the one from the cycle before
   task automatic busCycle(input logic wr, input logic [7:0] a, input logic [7:0] d,
                           input logic chk, input logic [7:0] e, output logic [7:0] got);
      int waited;
      waited = 0;
      got    = '0;
      cyc      <= 1'b1;
      stb      <= 1'b1;
      we       <= wr;
      adr      <= a;
      datW     <= d;
      expCheck <= chk;
      expData  <= e;
      do begin
         @(posedge clk);
         waited++;
      end while (!ack && waited < 50);
      if (ack) begin
         got = datR;
      end else begin
         $display("timeout waiting for ack on bus access to 0x%0h", a);
         timeouts++;
         aborted = 1'b1;
      end
      cyc      <= 1'b0;
      stb      <= 1'b0;
      we       <= 1'b0;
      expCheck <= 1'b0;
      @(posedge clk);
   endtask

   task automatic pollReady();
      logic [7:0] status;
      int         polls;
      status = '0;
      polls  = 0;
      while (!status[0] && !aborted && polls < 20) begin
         busCycle(1'b0, regStatus, 8'h00, 1'b0, 8'h00, status);
         polls++;
      end
      if (!status[0] && !aborted) begin
         $display("timeout waiting for the status register to report ready");
         timeouts++;
         aborted = 1'b1;
      end
   endtask

   initial begin
      logic [7:0] got;
      void'($urandom(32'h12b7));
      timeouts = 0;
      aborted  = 1'b0;
      rstsb    <= 1'b0;
      cyc      <= 1'b0;
      stb      <= 1'b0;
      we       <= 1'b0;
      adr      <= '0;
      datW     <= '0;
      expCheck <= 1'b0;
      expData  <= '0;
      buildTable();
      repeat (3) @(posedge clk);
      rstsb <= 1'b1;
      @(posedge clk);
      foreach (steps[i]) begin
         if (!aborted) begin
            case (steps[i].op)
               opWrite: busCycle(1'b1, steps[i].adr, steps[i].data, 1'b0, 8'h00, got);
               opRead:  busCycle(1'b0, steps[i].adr, 8'h00, 1'b1, steps[i].expVal, got);
               default: pollReady();
            endcase
         end
      end
      repeat (3) @(posedge clk);
      $display("steps %0d  checker errors %0d  timeouts %0d", steps.size(), errCount, timeouts);
      if (errCount == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
hw/memIfPkg.sv
hw/wbRegDecoder.sv
hw/memRegBank.sv
hw/sramSequencer.sv
hw/memIfTop.sv
sim/sramModel.sv
sim/memIfChecker.sv
sim/memIfTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run and then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
   --top-module memIfTb -o memIfSim \
   && ./obj_dir/memIfSim > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -qx "TESTS PASSED" sim.log && exit 0 || exit 1
